/* axi_register_rd.f */
+incdir+src
src/axi_rd_pkg.sv
src/axi_ar_buffer.sv
src/axi_r_skid_buffer.sv
src/axi_register_rd.sv
tb/tb_axi_register_rd.sv

/* Makefile */
# verilator build and run for the axi read register slice

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP       := tb_axi_register_rd
FILELIST  := axi_register_rd.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "make test   build with verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

$(SIM): $(FILELIST) $(wildcard src/*.sv src/*.svh tb/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@./$(SIM) > $(LOG) 2>&1 || echo "TESTBENCH FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_axi_register_rd.sv */
// *************************************************************************
// testbench for the axi read register slice
// drives both read channels, checks payload, order and stall behavior
// *************************************************************************

`include "axi_rd_config.svh"

module tb_axi_register_rd
    import axi_rd_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_AR_PATH      = 16;
    localparam int N_R_FLOW       = 32;
    localparam int N_R_STALL      = 64;
    localparam int N_MIXED        = 32;
    localparam int N_AR_TOTAL     = N_AR_PATH + N_MIXED;
    localparam int N_R_TOTAL      = N_R_FLOW + N_R_STALL + N_MIXED;
    localparam int TIMEOUT_CYCLES = 4 * (N_AR_TOTAL + N_R_TOTAL) + 100;

    logic                       clk;
    logic                       rst;
    logic [`AXI_ID_WIDTH-1:0]   s_axi_arid;
    logic [`AXI_ADDR_WIDTH-1:0] s_axi_araddr;
    logic [7:0]                 s_axi_arlen;
    logic [2:0]                 s_axi_arsize;
    logic [1:0]                 s_axi_arburst;
    logic [2:0]                 s_axi_arprot;
    logic                       s_axi_arvalid;
    logic                       s_axi_arready;
    logic [`AXI_ID_WIDTH-1:0]   m_axi_arid;
    logic [`AXI_ADDR_WIDTH-1:0] m_axi_araddr;
    logic [7:0]                 m_axi_arlen;
    logic [2:0]                 m_axi_arsize;
    logic [1:0]                 m_axi_arburst;
    logic [2:0]                 m_axi_arprot;
    logic                       m_axi_arvalid;
    logic                       m_axi_arready;
    logic [`AXI_ID_WIDTH-1:0]   m_axi_rid;
    logic [`AXI_DATA_WIDTH-1:0] m_axi_rdata;
    logic [1:0]                 m_axi_rresp;
    logic                       m_axi_rlast;
    logic                       m_axi_rvalid;
    logic                       m_axi_rready;
    logic [`AXI_ID_WIDTH-1:0]   s_axi_rid;
    logic [`AXI_DATA_WIDTH-1:0] s_axi_rdata;
    logic [1:0]                 s_axi_rresp;
    logic                       s_axi_rlast;
    logic                       s_axi_rvalid;
    logic                       s_axi_rready;

    // stall pattern source
    logic [31:0] lfsr = 32'h9efd8d25;
    bit          ar_ready_random;
    bit          r_ready_random;

    // handshakes seen at the last rising edge
    bit          ar_in_fire;
    bit          ar_in_prev;
    bit          ar_out_fire;
    bit          r_in_fire;
    bit          r_out_fire;

    // beat indices in flight, oldest first
    int          ar_q[$];
    int          r_q[$];
    int          ar_next;
    int          r_next;
    int          ar_in_count;
    int          ar_out_count;
    int          r_in_count;
    int          r_out_count;

    string       test_name;
    int          test_count;
    int          checks;
    int          errors;
    int          errors_at_start;

    axi_register_rd axi_register_rd_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form, one step per bit taken
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'ha300_0000;
        end
        return out;
    endfunction

    // request fields follow from the index alone
    function automatic axi_ar_beat_t expected_ar(input int idx);
        axi_ar_beat_t beat;
        beat.id    = 8'(idx * 7 + 3);
        beat.addr  = 32'h4000_0000 + 32'(idx) * 32'h40;
        beat.len   = 8'(idx % 16);
        beat.size  = 3'(idx % 3);
        beat.burst = axi_burst_e'(2'(idx % 3));
        beat.prot  = 3'(idx);
        return beat;
    endfunction

    // last on every fourth beat, resp walks through all codes
    function automatic axi_r_beat_t expected_r(input int idx);
        axi_r_beat_t beat;
        beat.id   = 8'(idx);
        beat.data = 32'h9efd_0000 ^ (32'(idx) * 32'h0001_0101);
        beat.resp = axi_resp_e'(2'(idx % 4));
        beat.last = (idx % 4 == 3);
        return beat;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // downstream and upstream readys
    initial begin
        m_axi_arready = 1'b1;
        s_axi_rready  = 1'b1;
        forever begin
            @(negedge clk);
            m_axi_arready = ar_ready_random ? lfsr_bit() : 1'b1;
            s_axi_rready  = r_ready_random ? lfsr_bit() : 1'b1;
        end
    end

    // scoreboard, sampled on the rising edge
    always @(posedge clk) begin : compare_outputs
        int idx;
        if (!rst) begin
            ar_in_prev  = ar_in_fire;
            ar_in_fire  = s_axi_arvalid && s_axi_arready;
            ar_out_fire = m_axi_arvalid && m_axi_arready;
            r_in_fire   = m_axi_rvalid && m_axi_rready;
            r_out_fire  = s_axi_rvalid && s_axi_rready;

            if (ar_in_fire) begin
                ar_q.push_back(ar_next);
                ar_in_count++;
            end
            if (r_in_fire) begin
                r_q.push_back(r_next);
                r_in_count++;
            end

            if (ar_out_fire) begin
                ar_out_count++;
                if (ar_q.size() == 0) begin
                    errors++;
                    $display("%s: request left the slice with none pending", test_name);
                end else begin
                    idx = ar_q.pop_front();
                    check_value({test_name, "/ar beat"}, 64'(expected_ar(idx)),
                                64'({m_axi_arid, m_axi_araddr, m_axi_arlen,
                                     m_axi_arsize, m_axi_arburst, m_axi_arprot}));
                end
            end
            if (r_out_fire) begin
                r_out_count++;
                if (r_q.size() == 0) begin
                    errors++;
                    $display("%s: data beat left the slice with none pending", test_name);
                end else begin
                    idx = r_q.pop_front();
                    check_value({test_name, "/r beat"}, 64'(expected_r(idx)),
                                64'({s_axi_rid, s_axi_rdata, s_axi_rresp, s_axi_rlast}));
                end
            end

            // ar buffer never accepts on back to back cycles
            check_value({test_name, "/ar bubble"}, 64'd0, 64'(ar_in_fire && ar_in_prev));
            // skid buffer holds at most two beats
            check_value({test_name, "/r occupancy"}, 64'd1,
                        64'((r_in_count - r_out_count) <= 2));
        end
    end

    task automatic present_ar(input int idx);
        axi_ar_beat_t beat;
        beat          = expected_ar(idx);
        s_axi_arid    = beat.id;
        s_axi_araddr  = beat.addr;
        s_axi_arlen   = beat.len;
        s_axi_arsize  = beat.size;
        s_axi_arburst = beat.burst;
        s_axi_arprot  = beat.prot;
    endtask

    task automatic present_r(input int idx);
        axi_r_beat_t beat;
        beat        = expected_r(idx);
        m_axi_rid   = beat.id;
        m_axi_rdata = beat.data;
        m_axi_rresp = beat.resp;
        m_axi_rlast = beat.last;
    endtask

    // valid stays up until each request is taken
    task automatic drive_ar(input int count);
        int sent;
        sent = 0;
        @(negedge clk);
        present_ar(ar_next);
        s_axi_arvalid = 1'b1;
        while (sent < count) begin
            @(negedge clk);
            if (ar_in_fire) begin
                sent++;
                ar_next++;
                if (sent < count) begin
                    present_ar(ar_next);
                end else begin
                    s_axi_arvalid = 1'b0;
                end
            end
        end
    endtask

    task automatic drive_r(input int count);
        int sent;
        sent = 0;
        @(negedge clk);
        present_r(r_next);
        m_axi_rvalid = 1'b1;
        while (sent < count) begin
            @(negedge clk);
            if (r_in_fire) begin
                sent++;
                r_next++;
                if (sent < count) begin
                    present_r(r_next);
                end else begin
                    m_axi_rvalid = 1'b0;
                end
            end
        end
    endtask

    // no gaps once the first beat shows up
    task automatic check_rvalid_steady(input int target);
        while (!s_axi_rvalid) begin
            @(negedge clk);
        end
        while (r_out_count < target) begin
            check_value({test_name, "/rvalid gap"}, 64'd1, 64'(s_axi_rvalid));
            @(negedge clk);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic set_ready_mode(input bit ar_random, input bit r_random);
        @(posedge clk);
        ar_ready_random = ar_random;
        r_ready_random  = r_random;
    endtask

    task automatic finish_test();
        while (ar_out_count < ar_in_count || r_out_count < r_in_count) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_value({test_name, "/idle arvalid"}, 64'd0, 64'(m_axi_arvalid));
        check_value({test_name, "/idle rvalid"}, 64'd0, 64'(s_axi_rvalid));
        test_count++;
        $display("test %s finished with %0d errors", test_name, errors - errors_at_start);
    endtask

    initial begin : run_tests
        int target;
        rst           = 1'b1;
        s_axi_arid    = '0;
        s_axi_araddr  = '0;
        s_axi_arlen   = '0;
        s_axi_arsize  = '0;
        s_axi_arburst = '0;
        s_axi_arprot  = '0;
        s_axi_arvalid = 1'b0;
        m_axi_rid     = '0;
        m_axi_rdata   = '0;
        m_axi_rresp   = '0;
        m_axi_rlast   = 1'b0;
        m_axi_rvalid  = 1'b0;

        start_test("reset_state");
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            check_value({test_name, "/arvalid in reset"}, 64'd0, 64'(m_axi_arvalid));
            check_value({test_name, "/rvalid in reset"}, 64'd0, 64'(s_axi_rvalid));
            check_value({test_name, "/arready in reset"}, 64'd0, 64'(s_axi_arready));
            check_value({test_name, "/rready in reset"}, 64'd0, 64'(m_axi_rready));
        end
        rst = 1'b0;
        @(negedge clk);
        check_value({test_name, "/arvalid after reset"}, 64'd0, 64'(m_axi_arvalid));
        check_value({test_name, "/rvalid after reset"}, 64'd0, 64'(s_axi_rvalid));
        check_value({test_name, "/arready after reset"}, 64'd1, 64'(s_axi_arready));
        check_value({test_name, "/rready after reset"}, 64'd1, 64'(m_axi_rready));
        finish_test();

        start_test("ar_path");
        set_ready_mode(1'b0, 1'b0);
        drive_ar(N_AR_PATH);
        finish_test();

        start_test("r_throughput");
        set_ready_mode(1'b0, 1'b0);
        target = r_out_count + N_R_FLOW;
        fork
            drive_r(N_R_FLOW);
            check_rvalid_steady(target);
        join
        finish_test();

        start_test("r_backpressure");
        set_ready_mode(1'b0, 1'b1);
        drive_r(N_R_STALL);
        finish_test();

        // both channels busy, both stalled at random
        start_test("ar_backpressure");
        set_ready_mode(1'b1, 1'b1);
        fork
            drive_ar(N_MIXED);
            drive_r(N_MIXED);
        join
        finish_test();

        check_value("summary/ar delivered", 64'(N_AR_TOTAL), 64'(ar_out_count));
        check_value("summary/r delivered", 64'(N_R_TOTAL), 64'(r_out_count));
        $display("%0d tests, %0d checks, %0d errors", test_count, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // bound from the total beat count
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog: run hung, not finished after %0d cycles", TIMEOUT_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* src/axi_register_rd.sv */
// *************************************************************************
// axi4 read register slice
// cuts ar and r timing paths between an upstream master and a slave
// *************************************************************************

`include "axi_rd_config.svh"

module axi_register_rd
    import axi_rd_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    // read address from the master
    input  logic [`AXI_ID_WIDTH-1:0]   s_axi_arid,
    input  logic [`AXI_ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic [7:0]                 s_axi_arlen,
    input  logic [2:0]                 s_axi_arsize,
    input  logic [1:0]                 s_axi_arburst,
    input  logic [2:0]                 s_axi_arprot,
    input  logic                       s_axi_arvalid,
    output logic                       s_axi_arready,

    // read address to the slave
    output logic [`AXI_ID_WIDTH-1:0]   m_axi_arid,
    output logic [`AXI_ADDR_WIDTH-1:0] m_axi_araddr,
    output logic [7:0]                 m_axi_arlen,
    output logic [2:0]                 m_axi_arsize,
    output logic [1:0]                 m_axi_arburst,
    output logic [2:0]                 m_axi_arprot,
    output logic                       m_axi_arvalid,
    input  logic                       m_axi_arready,

    // read data from the slave
    input  logic [`AXI_ID_WIDTH-1:0]   m_axi_rid,
    input  logic [`AXI_DATA_WIDTH-1:0] m_axi_rdata,
    input  logic [1:0]                 m_axi_rresp,
    input  logic                       m_axi_rlast,
    input  logic                       m_axi_rvalid,
    output logic                       m_axi_rready,

    // read data to the master
    output logic [`AXI_ID_WIDTH-1:0]   s_axi_rid,
    output logic [`AXI_DATA_WIDTH-1:0] s_axi_rdata,
    output logic [1:0]                 s_axi_rresp,
    output logic                       s_axi_rlast,
    output logic                       s_axi_rvalid,
    input  logic                       s_axi_rready
);

    axi_ar_beat_t ar_in;
    axi_ar_beat_t ar_out;
    axi_r_beat_t  r_in;
    axi_r_beat_t  r_out;

    // ar channel packing
    assign ar_in = '{
        id:    s_axi_arid,
        addr:  s_axi_araddr,
        len:   s_axi_arlen,
        size:  s_axi_arsize,
        burst: axi_burst_e'(s_axi_arburst),
        prot:  s_axi_arprot
    };

    assign m_axi_arid    = ar_out.id;
    assign m_axi_araddr  = ar_out.addr;
    assign m_axi_arlen   = ar_out.len;
    assign m_axi_arsize  = ar_out.size;
    assign m_axi_arburst = ar_out.burst;
    assign m_axi_arprot  = ar_out.prot;

    // r channel packing
    assign r_in = '{
        id:   m_axi_rid,
        data: m_axi_rdata,
        resp: axi_resp_e'(m_axi_rresp),
        last: m_axi_rlast
    };

    assign s_axi_rid   = r_out.id;
    assign s_axi_rdata = r_out.data;
    assign s_axi_rresp = r_out.resp;
    assign s_axi_rlast = r_out.last;

    // address path, simple buffer with bubbles
    axi_ar_buffer ar_buffer_inst (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (ar_in),
        .in_valid  (s_axi_arvalid),
        .in_ready  (s_axi_arready),
        .out_beat  (ar_out),
        .out_valid (m_axi_arvalid),
        .out_ready (m_axi_arready)
    );

    // data path, skid buffer at full rate
    axi_r_skid_buffer r_skid_buffer_inst (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (r_in),
        .in_valid  (m_axi_rvalid),
        .in_ready  (m_axi_rready),
        .out_beat  (r_out),
        .out_valid (s_axi_rvalid),
        .out_ready (s_axi_rready)
    );

endmodule

/* src/axi_r_skid_buffer.sv */
// *************************************************************************
// read data channel skid buffer
// output and temp register, full throughput with a registered ready
// *************************************************************************

module axi_r_skid_buffer
    import axi_rd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // downstream slave side
    input  axi_r_beat_t in_beat,
    input  logic        in_valid,
    output logic        in_ready,

    // upstream master side
    output axi_r_beat_t out_beat,
    output logic        out_valid,
    input  logic        out_ready
);

    // temp holds the beat in flight when out_ready drops
    axi_r_beat_t temp_beat;
    logic        temp_valid;

    logic        out_valid_next;
    logic        temp_valid_next;
    logic        in_ready_early;

    logic        store_in_to_out;
    logic        store_in_to_temp;
    logic        store_temp_to_out;

    // keep ready up if output drains or temp cannot be filled this cycle
    assign in_ready_early = out_ready || (!temp_valid && (!out_valid || !in_valid));

    always_comb begin
        out_valid_next    = out_valid;
        temp_valid_next   = temp_valid;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (in_ready) begin
            if (out_ready || !out_valid) begin
                // output free or draining
                out_valid_next  = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the incoming beat
                temp_valid_next  = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            // parked beat goes out first
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready   <= 1'b0;
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            in_ready   <= in_ready_early;
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
        end
    end

    // payload steering
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_beat <= in_beat;
        end else if (store_temp_to_out) begin
            out_beat <= temp_beat;
        end

        if (store_in_to_temp) begin
            temp_beat <= in_beat;
        end
    end

    // temp only ever backs up a full output register
    property p_temp_behind_out;
        @(posedge clk) disable iff (rst)
        temp_valid |-> out_valid;
    endproperty

    a_temp_behind_out: assert property (p_temp_behind_out)
        else $error("r skid buffer: temp valid with output empty");

    // stalled beat must hold until the master takes it
    property p_out_stable;
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat));
    endproperty

    a_out_stable: assert property (p_out_stable)
        else $error("r skid buffer: out_beat changed while stalled");

endmodule

/* src/axi_ar_buffer.sv */
// *************************************************************************
// read address channel register, single entry
// registered ready, one request every second cycle
// *************************************************************************

module axi_ar_buffer
    import axi_rd_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // upstream side
    input  axi_ar_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,

    // downstream side
    output axi_ar_beat_t out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    logic out_valid_next;
    logic store_input;

    // output register is filled whenever ready was offered upstream
    always_comb begin
        out_valid_next = out_valid;
        store_input    = 1'b0;

        if (in_ready) begin
            out_valid_next = in_valid;
            store_input    = 1'b1;
        end else if (out_ready) begin
            // held request leaves, register drains
            out_valid_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            // ready only when the register will be empty
            in_ready  <= !out_valid_next;
            out_valid <= out_valid_next;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (store_input) begin
            out_beat <= in_beat;
        end
    end

    // stalled request must not change under the slave
    property p_out_stable;
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat));
    endproperty

    a_out_stable: assert property (p_out_stable)
        else $error("ar buffer: out_beat changed while stalled");

endmodule

/* src/axi_rd_pkg.sv */
// *************************************************************************
// axi read register slice types
// burst and response encodings, address and data beat structs
// *************************************************************************

`include "axi_rd_config.svh"

package axi_rd_pkg;

    // arburst encoding
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    // rresp encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // one read request, 56 bits
    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]   id;
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 len;
        logic [2:0]                 size;
        axi_burst_e                 burst;
        logic [2:0]                 prot;
    } axi_ar_beat_t;

    // one read data beat, 43 bits
    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]   id;
        logic [`AXI_DATA_WIDTH-1:0] data;
        axi_resp_e                  resp;
        logic                       last;
    } axi_r_beat_t;

endpackage

/* src/axi_rd_config.svh */
// *************************************************************************
// axi read register slice widths
// shared by the package and the top level ports
// *************************************************************************

`ifndef AXI_RD_CONFIG_SVH
`define AXI_RD_CONFIG_SVH

// transaction id width
`define AXI_ID_WIDTH 8

// byte address width
`define AXI_ADDR_WIDTH 32

// read data bus width
`define AXI_DATA_WIDTH 32

`endif
